// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_demux_subsystem
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
COMMON     := --timing --assert --timescale 1ns/100ps --top-module $(TOP)
VFLAGS     := --binary -j 0 $(COMMON) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only $(COMMON)
SOURCES    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES) logic/demux_defs.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+logic
logic/addr_map_pkg.sv
logic/bus_pkg.sv
logic/addr_rule_decoder.sv
logic/read_order_fifo.sv
logic/addr_demux.sv
logic/sram_target.sv
logic/demux_subsystem_top.sv
tests/tb_demux_subsystem.sv

// ==== logic/addr_demux.sv ====
// routes one requester to NUM_TARGETS memories by the rule table
// read responses return in issue order; writes get no response

`include "demux_defs.svh"

module addr_demux
  import addr_map_pkg::*;
  import bus_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  // upstream side
  input  mem_req_t                         req_i,
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  output mem_rsp_t                         rsp_o,
  output logic                             rsp_valid_o,
  input  logic                             rsp_ready_i,
  // rule table
  input  addr_rule_t [`NUM_RULES-1:0]      addr_map_i,
  // target side
  output mem_req_t                         tgt_req_o,
  output logic [`NUM_TARGETS-1:0]          tgt_req_valid_o,
  input  logic [`NUM_TARGETS-1:0]          tgt_req_ready_i,
  input  mem_rsp_t [`NUM_TARGETS-1:0]      tgt_rsp_i,
  input  logic [`NUM_TARGETS-1:0]          tgt_rsp_valid_i,
  output logic [`NUM_TARGETS-1:0]          tgt_rsp_ready_o
);

  target_idx_t req_tgt;
  target_sel_t req_sel;
  target_sel_t fifo_sel;
  target_sel_t head_sel;
  logic        fifo_full;
  logic        fifo_empty;
  logic        fifo_push;
  logic        fifo_pop;
  logic        slot_ok;

  addr_rule_decoder u_decoder (
    .addr_i       (req_i.addr),
    .rules_i      (addr_map_i),
    .target_idx_o (req_tgt)
  );

  assign req_sel = target_sel_t'(1'b1) << req_tgt;

  // a read needs a free FIFO slot, a write never does
  assign slot_ok = !fifo_full || req_i.write;

  assign tgt_req_o       = req_i;
  assign tgt_req_valid_o = (req_valid_i && slot_ok) ? req_sel : '0;
  assign req_ready_o     = slot_ok && tgt_req_ready_i[req_tgt];

  assign fifo_push = req_valid_i && req_ready_o && !req_i.write;
  assign fifo_pop  = rsp_valid_o && rsp_ready_i;

  read_order_fifo #(
    .DEPTH (`MAX_OUTSTANDING_READS)
  ) u_order_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (fifo_push),
    .sel_i    (req_sel),
    .pop_i    (fifo_pop),
    .sel_o    (fifo_sel),
    .full_o   (fifo_full),
    .empty_o  (fifo_empty)
  );

  // the head entry is stale storage while the FIFO is empty
  assign head_sel = fifo_empty ? '0 : fifo_sel;

  always_comb begin
    rsp_o       = '0;
    rsp_valid_o = 1'b0;
    for (int i = 0; i < `NUM_TARGETS; i++) begin
      if (head_sel[i]) begin
        rsp_o       = tgt_rsp_i[i];
        rsp_valid_o = tgt_rsp_valid_i[i];
      end
    end
  end

  // other targets keep their responses until they reach the head
  assign tgt_rsp_ready_o = head_sel & {`NUM_TARGETS{rsp_ready_i}};

  a_req_forwarded: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_valid_i && req_ready_o) |-> |(tgt_req_valid_o & tgt_req_ready_i));

  // an accepted write leaves the order FIFO untouched
  a_write_no_push: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_valid_i && req_ready_o && req_i.write) |=> $stable(u_order_fifo.wr_ptr));

endmodule

// ==== logic/addr_map_pkg.sv ====
// address map types; a rule matches when (addr & mask) == value
// the rule table is configuration and must stay constant after reset

`include "demux_defs.svh"

package addr_map_pkg;

  // byte address
  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  // binary target index
  typedef logic [$clog2(`NUM_TARGETS)-1:0] target_idx_t;

  // one-hot target selection, bit i for target i
  typedef logic [`NUM_TARGETS-1:0] target_sel_t;

  typedef struct packed {
    addr_t       mask;
    addr_t       value;
    target_idx_t target_idx;
  } addr_rule_t;

endpackage

// ==== logic/addr_rule_decoder.sv ====
// first matching rule wins; with no match the address goes to rule 0's target
// purely combinational

`include "demux_defs.svh"

module addr_rule_decoder
  import addr_map_pkg::*;
(
  input  addr_t                         addr_i,
  input  addr_rule_t [`NUM_RULES-1:0]   rules_i,
  output target_idx_t                   target_idx_o
);

  logic [`NUM_RULES-1:0] rule_match;

  // all rules are compared in parallel
  always_comb begin
    for (int i = 0; i < `NUM_RULES; i++) begin
      rule_match[i] = (addr_i & rules_i[i].mask) == rules_i[i].value;
    end
  end

  // scan from the highest rule down so the lowest match is the last to write
  always_comb begin
    target_idx_o = rules_i[0].target_idx;
    for (int i = `NUM_RULES - 1; i >= 0; i--) begin
      if (rule_match[i]) begin
        target_idx_o = rules_i[i].target_idx;
      end
    end
  end

endmodule

// ==== logic/bus_pkg.sv ====
// request and response payloads of the memory bus
// handshake signals travel next to these structs, not inside them

`include "demux_defs.svh"

package bus_pkg;

  import addr_map_pkg::*;

  // one data word
  typedef logic [`DATA_WIDTH-1:0] data_t;

  // wdata is ignored for reads
  typedef struct packed {
    addr_t addr;
    logic  write;
    data_t wdata;
  } mem_req_t;

  // reads only; writes get no response
  typedef struct packed {
    data_t rdata;
  } mem_rsp_t;

endpackage

// ==== logic/demux_defs.svh ====
// sizing for the memory router; all widths are in bits
// NUM_TARGETS and MAX_OUTSTANDING_READS are expected to be powers of two

`ifndef DEMUX_DEFS_SVH
`define DEMUX_DEFS_SVH

// byte address and data word
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// memory targets and address-map rules
`define NUM_TARGETS 2
`define NUM_RULES 2

// reads in flight between demux and requester
`define MAX_OUTSTANDING_READS 4

// words per target memory
`define TARGET_WORDS 64

`endif

// ==== logic/demux_subsystem_top.sv ====
// router with two targets; target 1 is the slow one
// addr_map_i must be held constant after reset

`include "demux_defs.svh"

module demux_subsystem_top
  import addr_map_pkg::*;
  import bus_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  mem_req_t                    req_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  output mem_rsp_t                    rsp_o,
  output logic                        rsp_valid_o,
  input  logic                        rsp_ready_i,
  input  addr_rule_t [`NUM_RULES-1:0] addr_map_i
);

  mem_req_t                        tgt_req;
  logic [`NUM_TARGETS-1:0]         tgt_req_valid;
  logic [`NUM_TARGETS-1:0]         tgt_req_ready;
  mem_rsp_t [`NUM_TARGETS-1:0]     tgt_rsp;
  logic [`NUM_TARGETS-1:0]         tgt_rsp_valid;
  logic [`NUM_TARGETS-1:0]         tgt_rsp_ready;

  addr_demux u_demux (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .req_i           (req_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .rsp_o           (rsp_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .addr_map_i      (addr_map_i),
    .tgt_req_o       (tgt_req),
    .tgt_req_valid_o (tgt_req_valid),
    .tgt_req_ready_i (tgt_req_ready),
    .tgt_rsp_i       (tgt_rsp),
    .tgt_rsp_valid_i (tgt_rsp_valid),
    .tgt_rsp_ready_o (tgt_rsp_ready)
  );

  // fast target
  sram_target #(
    .READ_LATENCY (1)
  ) u_tgt0 (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (tgt_req),
    .req_valid_i (tgt_req_valid[0]),
    .req_ready_o (tgt_req_ready[0]),
    .rsp_o       (tgt_rsp[0]),
    .rsp_valid_o (tgt_rsp_valid[0]),
    .rsp_ready_i (tgt_rsp_ready[0])
  );

  // slow target
  sram_target #(
    .READ_LATENCY (3)
  ) u_tgt1 (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (tgt_req),
    .req_valid_i (tgt_req_valid[1]),
    .req_ready_o (tgt_req_ready[1]),
    .rsp_o       (tgt_rsp[1]),
    .rsp_valid_o (tgt_rsp_valid[1]),
    .rsp_ready_i (tgt_rsp_ready[1])
  );

endmodule

// ==== logic/read_order_fifo.sv ====
// order FIFO of one-hot target selections; DEPTH must be a power of two
// push when full or pop when empty is illegal

`include "demux_defs.svh"

module read_order_fifo
  import addr_map_pkg::*;
#(
  parameter int unsigned DEPTH = `MAX_OUTSTANDING_READS
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        push_i,
  input  target_sel_t sel_i,
  input  logic        pop_i,
  output target_sel_t sel_o,
  output logic        full_o,
  output logic        empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  target_sel_t            entries [DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [CNT_W-1:0]       fill;

  assign full_o  = fill == CNT_W'(DEPTH);
  assign empty_o = fill == '0;
  assign sel_o   = entries[rd_ptr];

  // pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push_i && !pop_i) begin
        fill <= fill + 1'b1;
      end else if (pop_i && !push_i) begin
        fill <= fill - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      entries[wr_ptr] <= sel_i;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_i |-> !full_o);

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> !empty_o);

endmodule

// ==== logic/sram_target.sv ====
// word-addressed memory, index wraps modulo TARGET_WORDS; reads return after
// READ_LATENCY edges when the output is free, writes are accepted at any time

`include "demux_defs.svh"

module sram_target
  import addr_map_pkg::*;
  import bus_pkg::*;
#(
  parameter int unsigned READ_LATENCY = 1
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  mem_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output mem_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i
);

  localparam int unsigned OFS_W = $clog2(`DATA_WIDTH / 8);
  localparam int unsigned IDX_W = $clog2(`TARGET_WORDS);

  data_t                   mem [`TARGET_WORDS];
  logic [IDX_W-1:0]        word_idx;
  logic [READ_LATENCY-1:0] pipe_valid;
  data_t                   pipe_data [READ_LATENCY];
  logic [READ_LATENCY:0]   can_load;
  logic                    hold_valid;
  mem_rsp_t                hold_rsp;
  logic                    rd_accept;
  logic                    wr_accept;

  assign word_idx = req_i.addr[OFS_W +: IDX_W];

  // a stage may load when it is empty or its successor can take its entry;
  // the top bit is the hold register
  always_comb begin
    can_load[READ_LATENCY] = !hold_valid || rsp_ready_i;
    for (int i = READ_LATENCY - 1; i >= 0; i--) begin
      can_load[i] = !pipe_valid[i] || can_load[i+1];
    end
  end

  // reads stop only when every stage and the hold register are full
  assign req_ready_o = req_i.write || can_load[0];
  assign rd_accept   = req_valid_i && req_ready_o && !req_i.write;
  assign wr_accept   = req_valid_i && req_ready_o && req_i.write;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pipe_valid <= '0;
      hold_valid <= 1'b0;
    end else begin
      if (can_load[0]) begin
        pipe_valid[0] <= rd_accept;
      end
      for (int i = 1; i < READ_LATENCY; i++) begin
        if (can_load[i]) begin
          pipe_valid[i] <= pipe_valid[i-1];
        end
      end
      if (can_load[READ_LATENCY]) begin
        hold_valid <= pipe_valid[READ_LATENCY-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      mem[word_idx] <= req_i.wdata;
    end
    if (rd_accept) begin
      pipe_data[0] <= mem[word_idx];
    end
    for (int i = 1; i < READ_LATENCY; i++) begin
      if (can_load[i] && pipe_valid[i-1]) begin
        pipe_data[i] <= pipe_data[i-1];
      end
    end
    if (can_load[READ_LATENCY] && pipe_valid[READ_LATENCY-1]) begin
      hold_rsp.rdata <= pipe_data[READ_LATENCY-1];
    end
  end

  assign rsp_o       = hold_rsp;
  assign rsp_valid_o = hold_valid;

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o)));

endmodule

// ==== tests/tb_demux_subsystem.sv ====
// testbench for the memory router; concurrent assertions below do all checking
// programs address bit 8 to select target 1, every other address goes to target 0

`include "demux_defs.svh"

module tb_demux_subsystem
  import addr_map_pkg::*;
  import bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int REQ_TIMEOUT   = 40;
  localparam int DRAIN_TIMEOUT = 200;

  logic                        clk_i = 1'b0;
  logic                        arst_n_i;
  mem_req_t                    req;
  logic                        req_valid;
  logic                        req_ready;
  mem_rsp_t                    rsp;
  logic                        rsp_valid;
  logic                        rsp_ready;
  addr_rule_t [`NUM_RULES-1:0] addr_map;

  integer seed = 32'h38eb_dd0b;
  data_t  ref_mem [`NUM_TARGETS][`TARGET_WORDS];
  data_t  exp_q [$];
  data_t  exp_head;
  int     outstanding = 0;
  string  test_name;
  int     errors = 0;
  int     err_mark;
  int     tests_run = 0;
  int     tests_failed = 0;
  logic   traffic_done;
  addr_t  rand_addr;

  demux_subsystem_top u_demux_subsystem_top (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .rsp_o       (rsp),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .addr_map_i  (addr_map)
  );

  always #10 clk_i = ~clk_i;

  // reference routing: bit 8 set hits rule 0 (target 1), the rest falls to target 0
  function automatic int target_of(addr_t addr);
    return addr[8] ? 1 : 0;
  endfunction

  // word index above the byte offset, wrapping over 64 words
  function automatic int word_of(addr_t addr);
    return int'(addr[7:2]);
  endfunction

  function automatic data_t fill_word(addr_t addr);
    return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic void push_expected(data_t d);
    exp_q.push_back(d);
    outstanding = exp_q.size();
    exp_head = exp_q[0];
  endfunction

  function automatic void pop_expected();
    if (exp_q.size() > 0) begin
      void'(exp_q.pop_front());
    end
    outstanding = exp_q.size();
    if (outstanding > 0) begin
      exp_head = exp_q[0];
    end
  endfunction

  task automatic abort_run(input string why);
    $display("%s: %s", test_name, why);
    $display("test failed");
    $finish;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != err_mark) begin
      tests_failed++;
    end
    $display("%-14s %s, %0d error(s)", test_name,
             (errors == err_mark) ? "ok" : "FAILED", errors - err_mark);
  endtask

  // drives one request and updates the reference model at the accepting edge
  task automatic send_req(input logic write, input addr_t addr, input data_t wdata);
    int waited;
    waited = 0;
    @(negedge clk_i);
    req.addr  = addr;
    req.write = write;
    req.wdata = wdata;
    req_valid = 1'b1;
    #1;
    while (!req_ready && waited < REQ_TIMEOUT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!req_ready) begin
      abort_run("request was never accepted");
    end else begin
      @(posedge clk_i);
      if (write) begin
        ref_mem[target_of(addr)][word_of(addr)] = wdata;
      end else begin
        push_expected(ref_mem[target_of(addr)][word_of(addr)]);
      end
    end
  endtask

  task automatic go_idle();
    @(negedge clk_i);
    req_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (outstanding > 0 && waited < DRAIN_TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (outstanding > 0) begin
      abort_run("read responses did not drain");
    end
  endtask

  // inputs settle at the falling edge, so a transfer seen here completes at the next rise
  initial begin
    forever begin
      @(negedge clk_i);
      #2;
      if (arst_n_i && rsp_valid && rsp_ready) begin
        @(posedge clk_i);
        #1;
        pop_expected();
      end
    end
  end

  a_rsp_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (rsp_valid && rsp_ready && outstanding > 0) |-> rsp.rdata == exp_head)
    else begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", test_name,
               $sampled(exp_head), $sampled(rsp));
    end

  a_no_spurious: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (outstanding == 0) |-> !rsp_valid)
    else begin
      errors++;
      $display("%s: response valid with no read outstanding", test_name);
    end

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
    else begin
      errors++;
      $display("%s: response changed while held under back-pressure", test_name);
    end

  a_reset_quiet: assert property (@(posedge clk_i) !arst_n_i |-> !rsp_valid)
    else begin
      errors++;
      $display("%s: response valid during reset", test_name);
    end

  a_read_limit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_valid && !req.write && outstanding >= `MAX_OUTSTANDING_READS) |-> !req_ready)
    else begin
      errors++;
      $display("%s: read accepted beyond the outstanding limit", test_name);
    end

  initial begin
    arst_n_i    = 1'b0;
    req         = '0;
    req_valid   = 1'b0;
    rsp_ready   = 1'b1;
    addr_map[0] = '{mask: 32'h0000_0100, value: 32'h0000_0100, target_idx: 1'b1};
    addr_map[1] = '{mask: 32'h0, value: 32'h0, target_idx: 1'b0};
    test_name   = "reset";
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    begin_test("idle");
    repeat (5) @(negedge clk_i);
    end_test();

    // preload both memories so that every read has a known value
    begin_test("write_read");
    for (int a = 0; a < 2 * `TARGET_WORDS * 4; a += 4) begin
      send_req(1'b1, addr_t'(a), fill_word(addr_t'(a)));
    end
    send_req(1'b1, 32'h0000_0040, 32'hcafe_0040);
    send_req(1'b0, 32'h0000_0040, '0);
    send_req(1'b1, 32'h0000_0144, 32'hbeef_0144);
    send_req(1'b0, 32'h0000_0144, '0);
    // same word index through the other target keeps its own data
    send_req(1'b0, 32'h0000_0140, '0);
    send_req(1'b0, 32'h0000_0044, '0);
    go_idle();
    wait_drain();
    end_test();

    // 0x308 satisfies both rules and also wraps onto word 2
    begin_test("rule_priority");
    send_req(1'b1, 32'h0000_0308, 32'h1234_abcd);
    send_req(1'b0, 32'h0000_0308, '0);
    send_req(1'b0, 32'h0000_0108, '0);
    send_req(1'b0, 32'h0000_0008, '0);
    go_idle();
    wait_drain();
    end_test();

    begin_test("ordering");
    for (int i = 0; i < 8; i++) begin
      send_req(1'b0, (i % 2 == 0) ? addr_t'(32'h100 + 4 * i) : addr_t'(4 * i), '0);
    end
    go_idle();
    wait_drain();
    end_test();

    begin_test("outstanding");
    @(negedge clk_i);
    rsp_ready = 1'b0;
    for (int i = 0; i < `MAX_OUTSTANDING_READS; i++) begin
      send_req(1'b0, addr_t'(32'h10 + 32'h100 * (i % 2) + 4 * i), '0);
    end
    // FIFO is full here, so only a write can get through
    send_req(1'b1, 32'h0000_0010, 32'h5555_aaaa);
    fork
      send_req(1'b0, 32'h0000_0110, '0);
      begin
        repeat (6) @(negedge clk_i);
        rsp_ready = 1'b1;
      end
    join
    go_idle();
    wait_drain();
    end_test();

    begin_test("random");
    traffic_done = 1'b0;
    fork
      begin
        for (int i = 0; i < 200; i++) begin
          rand_addr = $random(seed);
          send_req(($random(seed) & 3) == 0, rand_addr, $random(seed));
        end
        traffic_done = 1'b1;
      end
      begin
        while (!traffic_done) begin
          @(negedge clk_i);
          rsp_ready = ($random(seed) & 3) != 0;
        end
      end
    join
    go_idle();
    rsp_ready = 1'b1;
    wait_drain();
    end_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
